/* common/decode_pkg.sv */
/*
 Shared RV32I front-end definitions.
 Branch codes carry no signedness; alu_unsigned selects BLTU/BGEU.
 Byte enables assume an address offset of zero.
*/
package decode_pkg;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	localparam int FIFO_DEPTH = 8; // power of two

	localparam logic [3:0] BE_NONE = 4'b0000;
	localparam logic [3:0] BE_WORD = 4'b1111;
	localparam logic [3:0] BE_HALF = 4'b0011;
	localparam logic [3:0] BE_BYTE = 4'b0001;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLT    = 4'b0001,
		ALU_SLTU   = 4'b0010,
		ALU_AND    = 4'b0011,
		ALU_OR     = 4'b0100,
		ALU_XOR    = 4'b0101,
		ALU_SLL    = 4'b0110,
		ALU_SRL    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1001,
		ALU_PASS_B = 4'b1010  // lui result
	} alu_op_e;

	typedef enum logic [2:0] {
		BRN_NONE = 3'b000,
		BRN_EQ   = 3'b100,
		BRN_NE   = 3'b101,
		BRN_LT   = 3'b110,
		BRN_GE   = 3'b111
	} brn_e;

	typedef enum logic [1:0] {
		SZ_WORD = 2'b00,
		SZ_HALF = 2'b01,
		SZ_BYTE = 2'b10
	} mem_size_e;

	typedef enum logic [1:0] {
		CMD_OTHER = 2'b00,
		CMD_JMP   = 2'b01,
		CMD_ST    = 2'b10,
		CMD_LD    = 2'b11
	} mem_cmd_e;

	typedef enum logic [2:0] {
		IMM_I = 3'd0,
		IMM_S = 3'd1,
		IMM_B = 3'd2,
		IMM_U = 3'd3,
		IMM_J = 3'd4
	} imm_kind_e;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] insn;
	} fetch_item_t;

	typedef struct packed {
		logic [31:0] pc;
		alu_op_e     alu_op;
		logic        alu_unsigned;
		logic        a_sel_pc;     // operand a is the pc
		logic        b_sel_imm;    // operand b is the immediate
		imm_kind_e   imm_kind;
		brn_e        brn;
		logic        ld_signed;
		mem_size_e   mem_size;
		logic        we_reg;
		logic        we_mem;
		logic [3:0]  be;
		mem_cmd_e    cmd;
		logic        illegal;
	} ctrl_word_t;

endpackage

/* src/fetch_tagger.sv */
/*
 Pairs each instruction word with its PC, one register stage.
 The source must hold insn_valid low while insn_stall is high.
*/
module fetch_tagger (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    insn_valid,
	input  logic [31:0]             insn_word,
	input  logic                    redirect,
	input  logic [31:0]             redirect_pc,
	output logic                    push,
	output decode_pkg::fetch_item_t item
);

	logic [31:0] pc_q;
	logic [31:0] pc_cur;

	// redirect wins over the running pc in the same cycle
	assign pc_cur = redirect ? redirect_pc : pc_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= 32'd0;
			push <= 1'b0;
		end else begin
			push <= insn_valid;
			if (insn_valid) begin
				pc_q <= pc_cur + 32'd4;
			end else begin
				pc_q <= pc_cur; // hold target for next word
			end
		end
	end

	// payload stage
	always_ff @(posedge clk) begin
		if (insn_valid) begin
			item.pc   <= pc_cur;
			item.insn <= insn_word;
		end
	end

endmodule

/* src/insn_fifo.sv */
/*
 Show-ahead FIFO. rdata is valid whenever not_empty is high.
 DEPTH must be a power of two. Pushes into a full queue are dropped.
*/
module insn_fifo #(
	parameter type payload_t = decode_pkg::fetch_item_t,
	parameter int  DEPTH     = decode_pkg::FIFO_DEPTH
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t wdata,
	input  logic     pop,
	output payload_t rdata,
	output logic     not_empty,
	output logic     almost_full
);

	localparam int AW    = $clog2(DEPTH);
	localparam int CNT_W = AW + 1;

	payload_t         mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push     = push && (count != CNT_W'(DEPTH));
	assign do_pop      = pop && not_empty;
	assign not_empty   = (count != '0);
	assign almost_full = (count >= CNT_W'(DEPTH - 1)); // room for the tagger stage
	assign rdata       = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

endmodule

/* decoder/insn_decoder.sv */
/*
 RV32I decode of the queue head into a registered control word.
 Only opcode, funct3 and bit 30 are examined. CSR, fence and
 compressed encodings come out illegal with no write enables.
*/
module insn_decoder (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    not_empty,
	input  decode_pkg::fetch_item_t head,
	input  logic                    decode_hold,
	output logic                    pop,
	output logic                    ctrl_valid,
	output decode_pkg::ctrl_word_t  ctrl
);

	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic                   bit30;
	logic                   is_op;
	decode_pkg::ctrl_word_t dec;

	assign opcode = head.insn[6:0];
	assign funct3 = head.insn[14:12];
	assign bit30  = head.insn[30];
	assign is_op  = (opcode == decode_pkg::OPC_OP);

	assign pop = not_empty && !decode_hold;

	always_comb begin
		dec.pc           = head.pc;
		dec.alu_op       = decode_pkg::ALU_ADD;
		dec.alu_unsigned = 1'b0;
		dec.a_sel_pc     = 1'b0;
		dec.b_sel_imm    = 1'b0;
		dec.imm_kind     = decode_pkg::IMM_I;
		dec.brn          = decode_pkg::BRN_NONE;
		dec.ld_signed    = 1'b0;
		dec.mem_size     = decode_pkg::SZ_WORD;
		dec.we_reg       = 1'b0;
		dec.we_mem       = 1'b0;
		dec.be           = decode_pkg::BE_NONE;
		dec.cmd          = decode_pkg::CMD_OTHER;
		dec.illegal      = 1'b0;

		case (opcode)
			decode_pkg::OPC_OP, decode_pkg::OPC_OP_IMM: begin
				dec.b_sel_imm = !is_op;
				dec.we_reg    = 1'b1;
				dec.illegal   = is_op && bit30; // cleared below for sub/sra
				case (funct3)
					3'b000: begin
						dec.alu_op  = (is_op && bit30) ? decode_pkg::ALU_SUB
						                               : decode_pkg::ALU_ADD;
						dec.illegal = 1'b0;
					end
					3'b001: dec.alu_op = decode_pkg::ALU_SLL;
					3'b010: dec.alu_op = decode_pkg::ALU_SLT;
					3'b011: begin
						dec.alu_op       = decode_pkg::ALU_SLTU;
						dec.alu_unsigned = 1'b1;
					end
					3'b100: dec.alu_op = decode_pkg::ALU_XOR;
					3'b101: begin
						dec.alu_op  = bit30 ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
						dec.illegal = 1'b0;
					end
					3'b110: dec.alu_op = decode_pkg::ALU_OR;
					default: dec.alu_op = decode_pkg::ALU_AND;
				endcase
			end
			decode_pkg::OPC_LUI: begin
				dec.alu_op    = decode_pkg::ALU_PASS_B;
				dec.b_sel_imm = 1'b1;
				dec.imm_kind  = decode_pkg::IMM_U;
				dec.we_reg    = 1'b1;
			end
			decode_pkg::OPC_AUIPC: begin
				dec.a_sel_pc  = 1'b1;
				dec.b_sel_imm = 1'b1;
				dec.imm_kind  = decode_pkg::IMM_U;
				dec.we_reg    = 1'b1;
			end
			decode_pkg::OPC_BRANCH: begin
				dec.alu_op       = decode_pkg::ALU_SUB; // compare rs1 with rs2
				dec.imm_kind     = decode_pkg::IMM_B;
				dec.alu_unsigned = funct3[1];
				case (funct3)
					3'b000: dec.brn = decode_pkg::BRN_EQ;
					3'b001: dec.brn = decode_pkg::BRN_NE;
					3'b100, 3'b110: dec.brn = decode_pkg::BRN_LT;
					3'b101, 3'b111: dec.brn = decode_pkg::BRN_GE;
					default: dec.illegal = 1'b1;
				endcase
			end
			decode_pkg::OPC_JAL: begin
				dec.a_sel_pc  = 1'b1; // target is pc + imm
				dec.b_sel_imm = 1'b1;
				dec.imm_kind  = decode_pkg::IMM_J;
				dec.we_reg    = 1'b1;
				dec.cmd       = decode_pkg::CMD_JMP;
			end
			decode_pkg::OPC_JALR: begin
				dec.b_sel_imm = 1'b1;
				dec.we_reg    = 1'b1;
				dec.cmd       = decode_pkg::CMD_JMP;
				dec.illegal   = (funct3 != 3'b000);
			end
			decode_pkg::OPC_LOAD: begin
				dec.b_sel_imm = 1'b1; // address is rs1 + imm
				dec.we_reg    = 1'b1;
				dec.cmd       = decode_pkg::CMD_LD;
				dec.ld_signed = !funct3[2];
				case (funct3)
					3'b000, 3'b100: begin
						dec.mem_size = decode_pkg::SZ_BYTE;
						dec.be       = decode_pkg::BE_BYTE;
					end
					3'b001, 3'b101: begin
						dec.mem_size = decode_pkg::SZ_HALF;
						dec.be       = decode_pkg::BE_HALF;
					end
					3'b010: dec.be = decode_pkg::BE_WORD;
					default: dec.illegal = 1'b1;
				endcase
			end
			decode_pkg::OPC_STORE: begin
				dec.b_sel_imm = 1'b1;
				dec.imm_kind  = decode_pkg::IMM_S;
				dec.we_mem    = 1'b1;
				dec.cmd       = decode_pkg::CMD_ST;
				case (funct3)
					3'b000: begin
						dec.mem_size = decode_pkg::SZ_BYTE;
						dec.be       = decode_pkg::BE_BYTE;
					end
					3'b001: begin
						dec.mem_size = decode_pkg::SZ_HALF;
						dec.be       = decode_pkg::BE_HALF;
					end
					3'b010: dec.be = decode_pkg::BE_WORD;
					default: dec.illegal = 1'b1;
				endcase
			end
			default: dec.illegal = 1'b1; // unknown opcode
		endcase

		// an illegal word must not touch architectural state
		if (dec.illegal) begin
			dec.we_reg    = 1'b0;
			dec.we_mem    = 1'b0;
			dec.be        = decode_pkg::BE_NONE;
			dec.brn       = decode_pkg::BRN_NONE;
			dec.ld_signed = 1'b0;
			dec.cmd       = decode_pkg::CMD_OTHER;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_valid <= 1'b0;
		end else begin
			ctrl_valid <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			ctrl <= dec;
		end
	end

endmodule

/* src/decode_front.sv */
/*
 Fetch tagger, instruction FIFO and decoder in a chain.
 ctrl_valid follows insn_valid by 3 cycles when idle.
*/
module decode_front (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   insn_valid,
	input  logic [31:0]            insn_word,
	input  logic                   redirect,
	input  logic [31:0]            redirect_pc,
	input  logic                   decode_hold,
	output logic                   insn_stall,
	output logic                   ctrl_valid,
	output decode_pkg::ctrl_word_t ctrl
);

	logic                    push;
	logic                    pop;
	logic                    not_empty;
	decode_pkg::fetch_item_t tag_item;
	decode_pkg::fetch_item_t head_item;

	fetch_tagger tagger0 (
		.clk         (clk),
		.rst         (rst),
		.insn_valid  (insn_valid),
		.insn_word   (insn_word),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.push        (push),
		.item        (tag_item)
	);

	insn_fifo #(
		.payload_t (decode_pkg::fetch_item_t),
		.DEPTH     (decode_pkg::FIFO_DEPTH)
	) fifo0 (
		.clk         (clk),
		.rst         (rst),
		.push        (push),
		.wdata       (tag_item),
		.pop         (pop),
		.rdata       (head_item),
		.not_empty   (not_empty),
		.almost_full (insn_stall)
	);

	insn_decoder decoder0 (
		.clk         (clk),
		.rst         (rst),
		.not_empty   (not_empty),
		.head        (head_item),
		.decode_hold (decode_hold),
		.pop         (pop),
		.ctrl_valid  (ctrl_valid),
		.ctrl        (ctrl)
	);

endmodule

/* verif/decode_model.svh */
/*
 Reference RV32I decode for the testbench, built from the encoding rules.
 Illegal words only promise no writes, no byte enables and CMD_OTHER.
*/
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

decode_pkg::ctrl_word_t exp_q[$]; // expected words in issue order

function automatic decode_pkg::ctrl_word_t model_decode(input logic [31:0] pc,
		input logic [31:0] insn);
	decode_pkg::ctrl_word_t w;
	logic [6:0] opc;
	logic [2:0] f3;
	logic       alt;
	opc  = insn[6:0];
	f3   = insn[14:12];
	alt  = insn[30];
	w    = '0; // ALU_ADD, IMM_I, BRN_NONE, SZ_WORD, CMD_OTHER
	w.pc = pc;
	if (opc == decode_pkg::OPC_OP || opc == decode_pkg::OPC_OP_IMM) begin
		w.we_reg       = 1'b1;
		w.b_sel_imm    = (opc == decode_pkg::OPC_OP_IMM);
		w.alu_unsigned = (f3 == 3'b011);
		case (f3)
			3'b000: w.alu_op = (alt && opc == decode_pkg::OPC_OP) ? decode_pkg::ALU_SUB
			                                                       : decode_pkg::ALU_ADD;
			3'b001: w.alu_op = decode_pkg::ALU_SLL;
			3'b010: w.alu_op = decode_pkg::ALU_SLT;
			3'b011: w.alu_op = decode_pkg::ALU_SLTU;
			3'b100: w.alu_op = decode_pkg::ALU_XOR;
			3'b101: w.alu_op = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
			3'b110: w.alu_op = decode_pkg::ALU_OR;
			default: w.alu_op = decode_pkg::ALU_AND;
		endcase
		// only sub and sra may carry bit 30 in a register op
		w.illegal = (opc == decode_pkg::OPC_OP) && alt && f3 != 3'b000 && f3 != 3'b101;
	end else if (opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC) begin
		w.we_reg    = 1'b1;
		w.b_sel_imm = 1'b1;
		w.imm_kind  = decode_pkg::IMM_U;
		w.a_sel_pc  = (opc == decode_pkg::OPC_AUIPC);
		w.alu_op    = w.a_sel_pc ? decode_pkg::ALU_ADD : decode_pkg::ALU_PASS_B;
	end else if (opc == decode_pkg::OPC_JAL || opc == decode_pkg::OPC_JALR) begin
		w.we_reg    = 1'b1;
		w.b_sel_imm = 1'b1;
		w.cmd       = decode_pkg::CMD_JMP;
		w.a_sel_pc  = (opc == decode_pkg::OPC_JAL);
		w.imm_kind  = w.a_sel_pc ? decode_pkg::IMM_J : decode_pkg::IMM_I;
		w.illegal   = (opc == decode_pkg::OPC_JALR) && f3 != 3'b000;
	end else if (opc == decode_pkg::OPC_BRANCH) begin
		w.alu_op       = decode_pkg::ALU_SUB;
		w.imm_kind     = decode_pkg::IMM_B;
		w.alu_unsigned = f3[1];
		w.illegal      = (f3 == 3'b010 || f3 == 3'b011);
		if (f3 == 3'b000) w.brn = decode_pkg::BRN_EQ;
		else if (f3 == 3'b001) w.brn = decode_pkg::BRN_NE;
		else w.brn = f3[0] ? decode_pkg::BRN_GE : decode_pkg::BRN_LT;
	end else if (opc == decode_pkg::OPC_LOAD || opc == decode_pkg::OPC_STORE) begin
		w.b_sel_imm = 1'b1;
		w.we_reg    = (opc == decode_pkg::OPC_LOAD);
		w.we_mem    = (opc == decode_pkg::OPC_STORE);
		w.cmd       = w.we_mem ? decode_pkg::CMD_ST : decode_pkg::CMD_LD;
		w.imm_kind  = w.we_mem ? decode_pkg::IMM_S : decode_pkg::IMM_I;
		w.ld_signed = w.we_reg && !f3[2];
		w.mem_size  = (f3[1:0] == 2'b00) ? decode_pkg::SZ_BYTE :
		              (f3[1:0] == 2'b01) ? decode_pkg::SZ_HALF : decode_pkg::SZ_WORD;
		w.be        = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
		// loads allow lbu/lhu, stores only the three sizes
		w.illegal   = (f3[1:0] == 2'b11) || (f3[2] && (w.we_mem || f3[1]));
	end else begin
		w.illegal = 1'b1;
	end
	if (w.illegal) begin
		w.we_reg    = 1'b0;
		w.we_mem    = 1'b0;
		w.be        = 4'b0000;
		w.ld_signed = 1'b0;
		w.cmd       = decode_pkg::CMD_OTHER;
	end
	return w;
endfunction

`endif

/* verif/tb_decode_front.sv */
/*
 Testbench for decode_front. Random stimulus from seed 70, checked against
 the decode model. The source always obeys insn_stall.
*/
module tb_decode_front;

	timeunit 1ns;
	timeprecision 100ps;

	`include "decode_model.svh"

	localparam int N_COV = 37;
	localparam int N_ILL = 200;
	localparam int N_LAT = 4;
	localparam int N_RED = 150;
	localparam int N_BP  = 300;
	localparam int WATCHDOG_CYCLES = (N_COV + N_ILL + N_LAT + N_RED + N_BP) * 20;

	logic                   clk;
	logic                   rst;
	logic                   insn_valid;
	logic [31:0]            insn_word;
	logic                   redirect;
	logic [31:0]            redirect_pc;
	logic                   decode_hold;
	logic                   insn_stall;
	logic                   ctrl_valid;
	decode_pkg::ctrl_word_t ctrl;

	integer                 seed;
	int                     errors;
	int                     checks;
	int                     words_seen;
	int                     stall_cycles;
	logic                   hold_rand; // randomize decode_hold each cycle
	logic [31:0]            model_pc;
	logic [31:0]            cov_words[$];
	decode_pkg::ctrl_word_t exp_head;

	decode_front dut0 (
		.clk         (clk),
		.rst         (rst),
		.insn_valid  (insn_valid),
		.insn_word   (insn_word),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.decode_hold (decode_hold),
		.insn_stall  (insn_stall),
		.ctrl_valid  (ctrl_valid),
		.ctrl        (ctrl)
	);

	always #4 clk = ~clk;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ctrl(input decode_pkg::ctrl_word_t got,
			input decode_pkg::ctrl_word_t exp);
		compare("ctrl.pc", got.pc, exp.pc);
		compare("ctrl.illegal", got.illegal, exp.illegal);
		compare("ctrl.we_reg", got.we_reg, exp.we_reg);
		compare("ctrl.we_mem", got.we_mem, exp.we_mem);
		compare("ctrl.cmd", got.cmd, exp.cmd);
		compare("ctrl.be", got.be, exp.be);
		if (!exp.illegal) begin
			compare("ctrl.alu_op", got.alu_op, exp.alu_op);
			compare("ctrl.alu_unsigned", got.alu_unsigned, exp.alu_unsigned);
			compare("ctrl.a_sel_pc", got.a_sel_pc, exp.a_sel_pc);
			compare("ctrl.b_sel_imm", got.b_sel_imm, exp.b_sel_imm);
			compare("ctrl.imm_kind", got.imm_kind, exp.imm_kind);
			compare("ctrl.brn", got.brn, exp.brn);
			compare("ctrl.ld_signed", got.ld_signed, exp.ld_signed);
			compare("ctrl.mem_size", got.mem_size, exp.mem_size);
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && ctrl_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at %0t ns: control word arrived with none outstanding", $time);
				errors++;
			end else begin
				exp_head = exp_q.pop_front();
				check_ctrl(ctrl, exp_head);
				words_seen++;
			end
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [31:0] pick_word();
		return cov_words[rand_word() % cov_words.size()];
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] opc, input logic [2:0] f3,
			input logic alt);
		return {1'b0, alt, 5'b00011, 5'd2, 5'd1, f3, 5'd3, opc}; // rs2=2 rs1=1 rd=3
	endfunction

	task automatic build_cov_list();
		for (int f = 0; f < 8; f++) begin
			cov_words.push_back(encode(decode_pkg::OPC_OP, 3'(f), 1'b0));
			cov_words.push_back(encode(decode_pkg::OPC_OP_IMM, 3'(f), 1'b0));
			if (f != 2 && f != 3) begin
				cov_words.push_back(encode(decode_pkg::OPC_BRANCH, 3'(f), 1'b0));
			end
			if (f != 3 && f < 6) begin
				cov_words.push_back(encode(decode_pkg::OPC_LOAD, 3'(f), 1'b0));
			end
			if (f < 3) begin
				cov_words.push_back(encode(decode_pkg::OPC_STORE, 3'(f), 1'b0));
			end
		end
		cov_words.push_back(encode(decode_pkg::OPC_OP, 3'b000, 1'b1));     // sub
		cov_words.push_back(encode(decode_pkg::OPC_OP, 3'b101, 1'b1));     // sra
		cov_words.push_back(encode(decode_pkg::OPC_OP_IMM, 3'b101, 1'b1)); // srai
		cov_words.push_back(encode(decode_pkg::OPC_LUI, 3'b000, 1'b0));
		cov_words.push_back(encode(decode_pkg::OPC_AUIPC, 3'b000, 1'b0));
		cov_words.push_back(encode(decode_pkg::OPC_JAL, 3'b000, 1'b0));
		cov_words.push_back(encode(decode_pkg::OPC_JALR, 3'b000, 1'b0));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (hold_rand) begin
			decode_hold = (rand_word() % 4) != 0; // hold three cycles in four
		end
	endtask

	task automatic issue(input logic [31:0] word, input logic redir, input logic [31:0] target);
		logic [31:0] pc_use;
		while (insn_stall) begin
			stall_cycles++;
			next_cycle();
		end
		pc_use      = redir ? target : model_pc;
		insn_valid  = 1'b1;
		insn_word   = word;
		redirect    = redir;
		redirect_pc = target;
		exp_q.push_back(model_decode(pc_use, word));
		model_pc = pc_use + 32'd4;
		next_cycle();
		insn_valid = 1'b0;
		redirect   = 1'b0;
	endtask

	task automatic redirect_only(input logic [31:0] target);
		redirect    = 1'b1;
		redirect_pc = target;
		model_pc    = target;
		next_cycle();
		redirect = 1'b0;
	endtask

	task automatic finish_test(input string name, input int err_before);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 100) begin
			next_cycle();
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("ERROR at %0t ns: %0d control words never arrived", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end
		repeat (3) next_cycle(); // catches stray extra words
		$display("test %-12s done, %0d errors", name, errors - err_before);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int          err0;
		int          cycles;
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] t;
		seed        = 70;
		clk         = 1'b0;
		rst         = 1'b1;
		insn_valid  = 1'b0;
		insn_word   = 32'd0;
		redirect    = 1'b0;
		redirect_pc = 32'd0;
		decode_hold = 1'b0;
		hold_rand   = 1'b0;
		model_pc    = 32'd0;
		errors      = 0;
		checks      = 0;
		words_seen  = 0;
		build_cov_list();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		compare("insn_stall", insn_stall, 32'd0);
		compare("ctrl_valid", ctrl_valid, 32'd0);

		err0 = errors;
		for (int i = 0; i < N_COV; i++) begin
			issue(cov_words[i], 1'b0, 32'd0);
		end
		finish_test("coverage", err0);

		err0 = errors;
		for (int i = 0; i < N_ILL; i++) begin
			r = rand_word();
			if (r[31]) begin
				r[6:0] = pick_word() & 32'h7f; // keep a known opcode
			end
			issue(r, 1'b0, 32'd0);
		end
		finish_test("illegal", err0);

		err0 = errors;
		for (int i = 0; i < N_LAT; i++) begin
			issue(cov_words[i * 7], 1'b0, 32'd0);
			cycles = 1;
			while (!ctrl_valid && cycles < 10) begin
				next_cycle();
				cycles++;
			end
			compare("ctrl_valid latency", cycles, 32'd3);
			repeat (3) next_cycle();
		end
		finish_test("latency", err0);

		err0 = errors;
		for (int i = 0; i < N_RED; i++) begin
			r = rand_word();
			w = pick_word();
			t = rand_word() & ~32'd3;
			if (r[2:0] == 3'd0) begin
				issue(w, 1'b1, t); // same-cycle redirect
			end else if (r[2:0] == 3'd1) begin
				redirect_only(t);
				issue(w, 1'b0, 32'd0);
			end else begin
				issue(w, 1'b0, 32'd0);
			end
		end
		finish_test("redirect", err0);

		err0         = errors;
		stall_cycles = 0;
		hold_rand    = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			r = rand_word();
			w = r[0] ? pick_word() : rand_word();
			issue(w, 1'b0, 32'd0);
		end
		hold_rand   = 1'b0;
		decode_hold = 1'b0;
		if (stall_cycles == 0) begin
			$display("ERROR at %0t ns: insn_stall never rose under back-pressure", $time);
			errors++;
		end
		finish_test("backpressure", err0);

		$display("summary: 5 tests, %0d words, %0d checks, %0d errors",
			words_seen, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+verif
common/decode_pkg.sv
src/fetch_tagger.sv
src/insn_fifo.sv
decoder/insn_decoder.sv
src/decode_front.sv
verif/tb_decode_front.sv

/* Makefile */
# Verilator build and run of the decode front-end testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"

test:
	verilator --binary -Wno-fatal -f flist.f --top-module tb_decode_front \
		-Mdir obj_dir -o sim_decode_front
	./obj_dir/sim_decode_front > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "test: failed"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "test: no result in log"; exit 1)
	@echo "test: passed"

clean:
	rm -rf obj_dir sim.log
